/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_xt_peripherals
FILELIST  = sim.f
BIN       = obj_dir/V$(TOP)
PASS_MSG  = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* logic/bios_store.sv */
// BIOS ROM storage shared by the download port and the CPU.
// The loader owns the memory for as long as a download runs; otherwise
// the CPU reads it, and CPU writes have no path into it.

module bios_store #(
    parameter int AW = 16
) (
    input  logic                      clock,
    input  logic                      cpu_select_i,
    input  logic [AW-1:0]             cpu_addr_i,
    input  logic                      ioctl_download_i,
    input  logic                      ioctl_wr_i,
    input  logic [15:0]               ioctl_addr_i,
    input  logic [xt_pkg::DATA_W-1:0] ioctl_data_i,
    output logic [xt_pkg::DATA_W-1:0] data_o,
    output logic                      rom_busy_o
);
    import xt_pkg::*;

    logic [DATA_W-1:0] mem [0:(2**AW)-1];

    logic [AW-1:0] mem_addr;
    logic          mem_en;
    logic          mem_we;

    // download has priority over the CPU
    always_comb begin
        if (ioctl_download_i) begin
            mem_addr = ioctl_addr_i[AW-1:0];
            mem_en   = 1'b1;
            mem_we   = ioctl_wr_i;
        end else begin
            mem_addr = cpu_addr_i;
            mem_en   = cpu_select_i;
            mem_we   = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (mem_we) begin
            mem[mem_addr] <= ioctl_data_i;
        end
        if (mem_en) begin
            data_o <= mem[mem_addr];
        end
    end

    // holds off CPU read data while the loader owns the port
    always_ff @(posedge clock) begin
        rom_busy_o <= ioctl_download_i;
    end

endmodule

/* logic/io_decode.sv */
// Address decoder for the XT bus.
// Turns the current bus address into I/O slot, chip and memory selects.
// All selects are combinational and need address enable low.

module io_decode #(
    parameter int RAM_AW = 15
) (
    input  xt_pkg::bus_req_t  bus_i,
    input  logic              enable_cga_i,
    output xt_pkg::chip_sel_t sel_o
);
    import xt_pkg::*;

    bus_addr_u   addr;
    logic [9:0]  port;
    logic [5:0]  vram_hi;
    logic [19:0] mem_word;

    assign addr = bus_i.address;

    // 10-bit ISA port number
    assign port = {addr.io.port_hi, addr.io.slot, addr.io.offset};

    // upper bits of the memory view for the region compares
    assign vram_hi  = {addr.mem.bank, addr.mem.half, addr.mem.offset[14]};
    assign mem_word = {addr.mem.bank, addr.mem.half, addr.mem.offset};

    always_comb begin
        sel_o = '0;

        if (!bus_i.address_enable_n) begin
            // motherboard slots, 32 ports each below 100h
            if (addr.io.port_hi == 2'b00) begin
                case (addr.io.slot)
                    3'd0: sel_o.dma  = 1'b1;
                    3'd1: sel_o.pic  = 1'b1;
                    3'd2: sel_o.pit  = 1'b1;
                    3'd3: sel_o.ppi  = 1'b1;
                    3'd4: sel_o.page = 1'b1;
                    default: begin
                        // slots 5 to 7 are not used on this board
                    end
                endcase
            end

            // 3F8h to 3FFh
            sel_o.uart  = (port[9:3] == UART_BASE[9:3]);
            // 388h and 389h
            sel_o.opl   = (port[9:1] == OPL_BASE[9:1]);
            // C0h to C7h
            sel_o.tandy = (port[9:3] == TANDY_BASE[9:3]);

            // system RAM from address zero
            sel_o.ram  = ((mem_word >> RAM_AW) == '0);
            // colour text buffer, only with the CGA enabled
            sel_o.vram = enable_cga_i && (vram_hi == VRAM_BANK_HI);
            // BIOS in the top 64 KB
            sel_o.rom  = (addr.mem.bank == ROM_BANK);
        end
    end

endmodule

/* logic/kbd_ports.sv */
// PPI-style keyboard ports at 60h to 7Fh.
// Port A latches the scancode, port B is a control register whose bit 7
// acknowledges the key, and port C returns the input pins.

module kbd_ports (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      select_i,
    input  xt_pkg::bus_req_t          bus_i,
    input  logic [xt_pkg::DATA_W-1:0] keycode_i,
    input  logic                      keycode_valid_i,
    input  logic [xt_pkg::DATA_W-1:0] port_c_i,
    output logic                      irq_o,
    output logic [xt_pkg::DATA_W-1:0] data_o
);
    import xt_pkg::*;

    logic [DATA_W-1:0] port_a;
    logic [DATA_W-1:0] port_b;
    logic [1:0]        reg_sel;
    logic              write_b;
    logic              read_en;
    logic              clear_key;

    assign reg_sel   = bus_i.address[1:0];
    assign write_b   = select_i && !bus_i.io_write_n && (reg_sel == 2'd1);
    assign read_en   = select_i && !bus_i.io_read_n;
    assign clear_key = write_b && bus_i.data[CLEAR_BIT];

    always_ff @(posedge clock) begin
        if (reset) begin
            port_a <= '0;
            port_b <= '0;
            irq_o  <= 1'b0;
        end else begin
            if (write_b) begin
                port_b <= bus_i.data;
            end

            // a fresh key beats an acknowledge on the same edge
            if (keycode_valid_i) begin
                port_a <= keycode_i;
                irq_o  <= 1'b1;
            end else if (clear_key) begin
                port_a <= '0;
                irq_o  <= 1'b0;
            end
        end
    end

    // registered read, valid one clock after the strobe
    always_ff @(posedge clock) begin
        if (read_en) begin
            case (reg_sel)
                2'd0:    data_o <= port_a;
                2'd1:    data_o <= port_b;
                2'd2:    data_o <= port_c_i;
                // mode register is write-only on a real 8255
                default: data_o <= '1;
            endcase
        end
    end

endmodule

/* logic/read_mux.sv */
// Read data selection onto the chipset data bus.
// Fixed priority over the internal sources; anything else leaves the bus
// undriven with the chipset flag low.

module read_mux (
    input  xt_pkg::chip_sel_t         sel_i,
    input  xt_pkg::bus_req_t          bus_i,
    input  logic                      rom_busy_i,
    input  logic [xt_pkg::DATA_W-1:0] ppi_data_i,
    input  logic [xt_pkg::DATA_W-1:0] vram_data_i,
    input  logic [xt_pkg::DATA_W-1:0] rom_data_i,
    input  logic [xt_pkg::DATA_W-1:0] ram_data_i,
    output logic [xt_pkg::DATA_W-1:0] data_o,
    output logic                      from_chipset_o
);
    import xt_pkg::*;

    logic io_rd;
    logic mem_rd;

    assign io_rd  = !bus_i.io_read_n;
    assign mem_rd = !bus_i.memory_read_n;

    always_comb begin
        data_o         = {DATA_W{1'b0}};
        from_chipset_o = 1'b0;

        if (sel_i.ppi && io_rd) begin
            data_o         = ppi_data_i;
            from_chipset_o = 1'b1;
        end else if (sel_i.vram && mem_rd) begin
            data_o         = vram_data_i;
            from_chipset_o = 1'b1;
        end else if (sel_i.rom && mem_rd && !rom_busy_i) begin
            // ROM stays off the bus during a download
            data_o         = rom_data_i;
            from_chipset_o = 1'b1;
        end else if (sel_i.ram && mem_rd) begin
            data_o         = ram_data_i;
            from_chipset_o = 1'b1;
        end
    end

endmodule

/* logic/sys_ram.sv */
// Byte-wide single-port RAM with a registered read.
// Serves both the system RAM and the CPU side of the video RAM.

module sys_ram #(
    parameter int AW = 15
) (
    input  logic                      clock,
    input  logic                      select_i,
    input  logic                      write_i,
    input  logic [AW-1:0]             addr_i,
    input  logic [xt_pkg::DATA_W-1:0] data_i,
    output logic [xt_pkg::DATA_W-1:0] data_o
);
    import xt_pkg::*;

    logic [DATA_W-1:0] mem [0:(2**AW)-1];

    // write strobe arrives already qualified by the select
    always_ff @(posedge clock) begin
        if (write_i) begin
            mem[addr_i] <= data_i;
        end
    end

    // read data lags the address by one clock
    always_ff @(posedge clock) begin
        if (select_i) begin
            data_o <= mem[addr_i];
        end
    end

endmodule

/* logic/xt_peripherals.sv */
// Top level of the XT peripheral bus block.
// Connects the address decoder, system and video RAM, BIOS store,
// keyboard ports and the read multiplexer to one CPU bus.

module xt_peripherals #(
    parameter int RAM_AW  = 15,
    parameter int VRAM_AW = 14,
    parameter int ROM_AW  = 16
) (
    input  logic                      clock,
    input  logic                      reset,
    input  xt_pkg::bus_req_t          bus_i,
    input  logic                      enable_cga_i,
    input  logic                      ioctl_download_i,
    input  logic                      ioctl_wr_i,
    input  logic [15:0]               ioctl_addr_i,
    input  logic [xt_pkg::DATA_W-1:0] ioctl_data_i,
    input  logic [xt_pkg::DATA_W-1:0] keycode_i,
    input  logic                      keycode_valid_i,
    input  logic [xt_pkg::DATA_W-1:0] port_c_i,
    output xt_pkg::ext_sel_t          ext_cs_o,
    output logic                      kbd_irq_o,
    output logic [xt_pkg::DATA_W-1:0] data_bus_out_o,
    output logic                      data_bus_out_from_chipset_o
);
    import xt_pkg::*;

    chip_sel_t         sel;
    logic [DATA_W-1:0] ram_data;
    logic [DATA_W-1:0] vram_data;
    logic [DATA_W-1:0] rom_data;
    logic [DATA_W-1:0] ppi_data;
    logic              rom_busy;
    logic              mem_write;

    assign mem_write = !bus_i.memory_write_n;

    io_decode #(.RAM_AW(RAM_AW)) u_decode (
        .bus_i        (bus_i),
        .enable_cga_i (enable_cga_i),
        .sel_o        (sel)
    );

    // only the external chip selects leave the block
    assign ext_cs_o = '{
        dma:   sel.dma,
        pic:   sel.pic,
        pit:   sel.pit,
        page:  sel.page,
        uart:  sel.uart,
        opl:   sel.opl,
        tandy: sel.tandy
    };

    sys_ram #(.AW(RAM_AW)) u_ram (
        .clock    (clock),
        .select_i (sel.ram),
        .write_i  (sel.ram && mem_write),
        .addr_i   (bus_i.address[RAM_AW-1:0]),
        .data_i   (bus_i.data),
        .data_o   (ram_data)
    );

    sys_ram #(.AW(VRAM_AW)) u_vram (
        .clock    (clock),
        .select_i (sel.vram),
        .write_i  (sel.vram && mem_write),
        .addr_i   (bus_i.address[VRAM_AW-1:0]),
        .data_i   (bus_i.data),
        .data_o   (vram_data)
    );

    bios_store #(.AW(ROM_AW)) u_bios (
        .clock            (clock),
        .cpu_select_i     (sel.rom),
        .cpu_addr_i       (bus_i.address[ROM_AW-1:0]),
        .ioctl_download_i (ioctl_download_i),
        .ioctl_wr_i       (ioctl_wr_i),
        .ioctl_addr_i     (ioctl_addr_i),
        .ioctl_data_i     (ioctl_data_i),
        .data_o           (rom_data),
        .rom_busy_o       (rom_busy)
    );

    kbd_ports u_kbd (
        .clock           (clock),
        .reset           (reset),
        .select_i        (sel.ppi),
        .bus_i           (bus_i),
        .keycode_i       (keycode_i),
        .keycode_valid_i (keycode_valid_i),
        .port_c_i        (port_c_i),
        .irq_o           (kbd_irq_o),
        .data_o          (ppi_data)
    );

    read_mux u_mux (
        .sel_i          (sel),
        .bus_i          (bus_i),
        .rom_busy_i     (rom_busy),
        .ppi_data_i     (ppi_data),
        .vram_data_i    (vram_data),
        .rom_data_i     (rom_data),
        .ram_data_i     (ram_data),
        .data_o         (data_bus_out_o),
        .from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

/* logic/xt_pkg.sv */
// Shared types and address map of the XT peripheral block.
// Every module imports this package for the bus record, the chip selects
// and the decoder constants.

package xt_pkg;

    // bus widths
    localparam int ADDR_W = 20;
    localparam int DATA_W = 8;

    // one CPU bus cycle, ISA-style strobes, all active low
    typedef struct packed {
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] data;
        logic              io_read_n;
        logic              io_write_n;
        logic              memory_read_n;
        logic              memory_write_n;
        logic              address_enable_n;
    } bus_req_t;

    // I/O view, 10-bit port field split into slot and offset
    typedef struct packed {
        logic [9:0] upper;
        logic [1:0] port_hi;
        logic [2:0] slot;
        logic [4:0] offset;
    } io_addr_t;

    // memory view, 64 KB banks split in two 32 KB halves
    typedef struct packed {
        logic [3:0]  bank;
        logic        half;
        logic [14:0] offset;
    } mem_addr_t;

    typedef union packed {
        io_addr_t  io;
        mem_addr_t mem;
    } bus_addr_u;

    // all decoded selects, active high
    typedef struct packed {
        logic dma;
        logic pic;
        logic pit;
        logic page;
        logic uart;
        logic opl;
        logic tandy;
        logic ppi;
        logic ram;
        logic vram;
        logic rom;
    } chip_sel_t;

    // selects for the chips that sit outside this block
    typedef struct packed {
        logic dma;
        logic pic;
        logic pit;
        logic page;
        logic uart;
        logic opl;
        logic tandy;
    } ext_sel_t;

    // I/O bases of the chips outside the slot map
    localparam logic [9:0] UART_BASE  = 10'h3F8;
    localparam logic [9:0] OPL_BASE   = 10'h388;
    localparam logic [9:0] TANDY_BASE = 10'h0C0;

    // memory regions, matched on the upper address bits
    localparam logic [3:0] ROM_BANK     = 4'hF;
    localparam logic [5:0] VRAM_BANK_HI = 6'b1011_10;

    // port B bit that acknowledges the keyboard
    localparam int CLEAR_BIT = 7;

endpackage

/* sim.f */
logic/xt_pkg.sv
logic/io_decode.sv
logic/sys_ram.sv
logic/bios_store.sv
logic/kbd_ports.sv
logic/read_mux.sv
logic/xt_peripherals.sv
tests/tb_xt_peripherals.sv

/* tests/bus_patterns.txt */
// op_addr_data_ctl_exp in hex; op 0 mem wr, 1 mem rd, 2 io wr, 3 io rd, 4 load, 5 key,
// 6 select, 7 load end, 8 irq, F end; ctl bit 0 cga, bit 1 aen_n; exp 1xx is chipset data
0_00010_3C_0_000
0_07FFF_5A_0_000
1_00010_00_0_13C
1_07FFF_00_0_15A
1_09000_00_0_000
0_B8000_11_1_000
0_B8123_22_1_000
1_B8123_00_1_122
0_B8000_99_0_000
1_B8000_00_0_000
1_B8000_00_1_111
4_00000_EA_0_000
4_00001_5B_0_000
4_0FFF0_E0_0_000
1_F0000_00_0_000
7_00000_00_0_000
1_F0000_00_0_1EA
1_F0001_00_0_15B
1_FFFF0_00_0_1E0
0_F0001_00_0_000
1_F0001_00_0_15B
8_00000_00_0_000
5_00000_1C_0_001
3_00060_00_0_11C
2_00061_80_0_000
8_00000_00_0_000
3_00060_00_0_100
3_00061_00_0_180
3_00062_00_0_1C7
6_00000_00_0_040
6_00020_00_0_020
6_00040_00_0_010
6_00080_00_0_008
6_003F8_00_0_004
6_00388_00_0_002
6_000C0_00_0_001
6_00000_00_2_000
F_00000_00_0_000

/* tests/tb_xt_peripherals.sv */
// Testbench for the XT peripheral block.
// Reads bus operations and expected results from tests/bus_patterns.txt,
// runs each one on the DUT and compares read data, chip selects and IRQ.

module tb_xt_peripherals;
    import xt_pkg::*;

    localparam int PERIOD  = 40;
    localparam int MAX_OPS = 64;
    localparam logic [DATA_W-1:0] PORT_C = 8'hC7;

    // operation codes of the pattern file
    localparam logic [3:0] OP_MEM_WR   = 4'h0;
    localparam logic [3:0] OP_MEM_RD   = 4'h1;
    localparam logic [3:0] OP_IO_WR    = 4'h2;
    localparam logic [3:0] OP_IO_RD    = 4'h3;
    localparam logic [3:0] OP_LOAD     = 4'h4;
    localparam logic [3:0] OP_KEY      = 4'h5;
    localparam logic [3:0] OP_SEL      = 4'h6;
    localparam logic [3:0] OP_LOAD_END = 4'h7;
    localparam logic [3:0] OP_IRQ      = 4'h8;
    localparam logic [3:0] OP_END      = 4'hF;

    // ctl bit 0 is enable_cga, bit 1 is address_enable_n
    typedef struct packed {
        logic [3:0]  op;
        logic [19:0] addr;
        logic [7:0]  data;
        logic [3:0]  ctl;
        logic [11:0] exp_val;
    } pattern_t;

    logic [47:0]       raw [0:MAX_OPS-1];
    logic              clock;
    logic              reset;
    bus_req_t          bus;
    logic              enable_cga;
    logic              ioctl_download;
    logic              ioctl_wr;
    logic [15:0]       ioctl_addr;
    logic [DATA_W-1:0] ioctl_data;
    logic [DATA_W-1:0] keycode;
    logic              keycode_valid;
    ext_sel_t          ext_cs;
    logic              kbd_irq;
    logic [DATA_W-1:0] data_out;
    logic              from_chipset;
    int                errors_data = 0;
    int                errors_sel = 0;
    int                errors_irq = 0;
    int                errors_setup = 0;
    int                cycles = 0;
    int                cycle_limit = 0;
    int                num_ops;

    xt_peripherals #(.RAM_AW(15), .VRAM_AW(14), .ROM_AW(16)) xt_peripherals_i (
        .clock                       (clock),
        .reset                       (reset),
        .bus_i                       (bus),
        .enable_cga_i                (enable_cga),
        .ioctl_download_i            (ioctl_download),
        .ioctl_wr_i                  (ioctl_wr),
        .ioctl_addr_i                (ioctl_addr),
        .ioctl_data_i                (ioctl_data),
        .keycode_i                   (keycode),
        .keycode_valid_i             (keycode_valid),
        .port_c_i                    (PORT_C),
        .ext_cs_o                    (ext_cs),
        .kbd_irq_o                   (kbd_irq),
        .data_bus_out_o              (data_out),
        .data_bus_out_from_chipset_o (from_chipset)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: test did not end within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    // strobes follow the operation code, all others stay high
    task automatic drive_bus(input logic [3:0] op, input logic [19:0] addr,
                             input logic [DATA_W-1:0] data, input logic aen_n);
        bus.address          = addr;
        bus.data             = data;
        bus.io_read_n        = (op != OP_IO_RD);
        bus.io_write_n       = (op != OP_IO_WR);
        bus.memory_read_n    = (op != OP_MEM_RD);
        bus.memory_write_n   = (op != OP_MEM_WR);
        bus.address_enable_n = aen_n;
    endtask

    task automatic bus_idle();
        drive_bus(OP_SEL, 20'h00000, 8'h00, 1'b0);
    endtask

    task automatic check_data(input logic [DATA_W-1:0] got, input logic got_cs,
                              input logic [DATA_W-1:0] want, input logic want_cs);
        if (got !== want) begin
            errors_data = errors_data + 1;
            $display("FAIL t=%0t data_bus_out_o got %h expected %h", $time, got, want);
        end
        if (got_cs !== want_cs) begin
            errors_data = errors_data + 1;
            $display("FAIL t=%0t data_bus_out_from_chipset_o got %b expected %b",
                     $time, got_cs, want_cs);
        end
    endtask

    task automatic check_sel(input ext_sel_t got, input ext_sel_t want);
        if (got !== want) begin
            errors_sel = errors_sel + 1;
            $display("FAIL t=%0t ext_cs_o got %h expected %h", $time, got, want);
        end
    endtask

    task automatic check_irq(input logic got, input logic want);
        if (got !== want) begin
            errors_irq = errors_irq + 1;
            $display("FAIL t=%0t kbd_irq_o got %b expected %b", $time, got, want);
        end
    endtask

    // entered and left 5 units after a rising edge
    task automatic run_op(input pattern_t p);
        enable_cga = p.ctl[0];
        case (p.op)
            OP_MEM_WR, OP_MEM_RD, OP_IO_WR, OP_IO_RD, OP_SEL: begin
                drive_bus(p.op, p.addr, p.data, p.ctl[1]);
                @(posedge clock);
                #(PERIOD - 10);
                if (p.op == OP_MEM_RD || p.op == OP_IO_RD) begin
                    check_data(data_out, from_chipset, p.exp_val[7:0], p.exp_val[8]);
                end
                if (p.op == OP_SEL) begin
                    check_sel(ext_cs, ext_sel_t'(p.exp_val[6:0]));
                end
                @(posedge clock);
                #5;
                bus_idle();
            end
            OP_LOAD: begin
                ioctl_download = 1'b1;
                ioctl_wr       = 1'b1;
                ioctl_addr     = p.addr[15:0];
                ioctl_data     = p.data;
                @(posedge clock);
                #5;
                ioctl_wr = 1'b0;
            end
            OP_LOAD_END: begin
                ioctl_download = 1'b0;
                @(posedge clock);
                #5;
            end
            OP_KEY: begin
                keycode       = p.data;
                keycode_valid = 1'b1;
                @(posedge clock);
                #5;
                keycode_valid = 1'b0;
                #(PERIOD - 15);
                check_irq(kbd_irq, p.exp_val[0]);
                @(posedge clock);
                #5;
            end
            OP_IRQ: begin
                #(PERIOD - 15);
                check_irq(kbd_irq, p.exp_val[0]);
                @(posedge clock);
                #5;
            end
            default: begin
                errors_setup = errors_setup + 1;
                $display("unknown operation code %h in the pattern file", p.op);
            end
        endcase
    endtask

    initial begin
        reset          = 1'b1;
        enable_cga     = 1'b0;
        ioctl_download = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = 16'h0000;
        ioctl_data     = 8'h00;
        keycode        = 8'h00;
        keycode_valid  = 1'b0;
        bus_idle();

        // unread entries end the list
        for (int i = 0; i < MAX_OPS; i++) begin
            raw[i] = '1;
        end
        $readmemh("tests/bus_patterns.txt", raw);
        num_ops = 0;
        while (num_ops < MAX_OPS && raw[num_ops][47:44] != OP_END) begin
            num_ops++;
        end
        if (num_ops == 0) begin
            errors_setup = errors_setup + 1;
            $display("no operations were read from tests/bus_patterns.txt");
        end
        cycle_limit = num_ops * 4 + 100;

        repeat (4) @(posedge clock);
        #5;
        reset = 1'b0;

        for (int i = 0; i < num_ops; i++) begin
            run_op(pattern_t'(raw[i]));
        end

        $display("errors: data %0d, select %0d, irq %0d, setup %0d",
                 errors_data, errors_sel, errors_irq, errors_setup);
        if (errors_data + errors_sel + errors_irq + errors_setup == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
